/* conv_pkg.sv */
// ############################
// conv layer shared defs
// ############################

package conv_pkg;

	localparam int IWIDTH    = 8;   // pixels per row
	localparam int KHEIGHT   = 3;
	localparam int KWIDTH    = 3;
	localparam int OCHAN     = 4;   // output channels
	localparam int TAPS      = KHEIGHT * KWIDTH;
	localparam int BUF_DEPTH = KHEIGHT * IWIDTH;
	localparam int ROM_DEPTH = OCHAN * TAPS;
	localparam int READ_LAT  = 2;   // buffer and rom alike

	// top bit of the output slice, also the clip exponent
	localparam int ACC_TOP   = 35;

	typedef logic signed [17:0] sample_t;
	typedef logic signed [47:0] acc_t;
	typedef logic [4:0]         buf_addr_t;
	typedef logic [5:0]         rom_addr_t;
	typedef logic [15:0]        count_t;

	localparam sample_t SAMPLE_MAX = 18'sh1ffff;   // clip level

	typedef enum logic [1:0] {
		IDLE,
		INIT,
		ISSUE,
		ADVANCE
	} seq_state_t;

endpackage

/* conv_row_buffer.sv */
// ############################
// input row buffer
// ############################

`timescale 1ns/1ps

module conv_row_buffer (
	input  logic                clk_i,
	input  logic                reset_i,
	input  conv_pkg::sample_t   pixel_i,
	input  logic                pixel_valid_i,
	input  conv_pkg::buf_addr_t rd_addr_i,
	output conv_pkg::sample_t   pixel_o,
	output conv_pkg::count_t    wr_count_o
);

	conv_pkg::sample_t   mem [conv_pkg::BUF_DEPTH];   // KHEIGHT rows, circular
	conv_pkg::buf_addr_t wr_ptr;
	conv_pkg::buf_addr_t wr_addr_q;
	conv_pkg::sample_t   wr_data_q;
	logic                wr_en_q;
	conv_pkg::sample_t   rd_q;   // first read stage

	// write pointer wraps at the end of the last row
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wr_ptr  <= '0;
			wr_en_q <= 1'b0;
		end else begin
			wr_en_q <= pixel_valid_i;
			if (pixel_valid_i) begin
				if (wr_ptr == conv_pkg::buf_addr_t'(conv_pkg::BUF_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (pixel_valid_i) begin
			wr_addr_q <= wr_ptr;
			wr_data_q <= pixel_i;
		end
	end

	// count moves with the memory write
	always_ff @(posedge clk_i) begin
		if (reset_i)
			wr_count_o <= '0;
		else if (wr_en_q)
			wr_count_o <= wr_count_o + 1'b1;
	end

	always_ff @(posedge clk_i) begin
		if (wr_en_q)
			mem[wr_addr_q] <= wr_data_q;
		rd_q    <= mem[rd_addr_i];
		pixel_o <= rd_q;   // block ram style output reg
	end

	// the sequencer compares against this count, a wrap would restart a frame
	a_count_no_wrap : assert property (@(posedge clk_i) disable iff (reset_i)
		wr_en_q |-> (wr_count_o != '1));

endmodule

/* conv_weight_rom.sv */
// ############################
// weight rom
// ############################

`timescale 1ns/1ps

module conv_weight_rom (
	input  logic                clk_i,
	input  conv_pkg::rom_addr_t wt_addr_i,
	output conv_pkg::sample_t   weight_o
);

	conv_pkg::sample_t rom [conv_pkg::ROM_DEPTH];   // channel-major, TAPS per channel
	conv_pkg::sample_t rd_q;

	initial begin
		$readmemb("weights.mem", rom);
	end

	always_ff @(posedge clk_i) begin
		rd_q     <= rom[wt_addr_i];
		weight_o <= rd_q;   // matches the row buffer latency
	end

	// sequencer must wrap its weight counter before running off the table
	a_addr_range : assert property (@(posedge clk_i)
		wt_addr_i < conv_pkg::rom_addr_t'(conv_pkg::ROM_DEPTH));

endmodule

/* conv_patch_sequencer.sv */
// ############################
// patch sequencer
// ############################

`timescale 1ns/1ps

module conv_patch_sequencer (
	input  logic                clk_i,
	input  logic                reset_i,
	input  conv_pkg::count_t    wr_count_i,
	output conv_pkg::buf_addr_t rd_addr_o,
	output conv_pkg::rom_addr_t wt_addr_o,
	output logic                tap_valid_o,
	output logic                tap_first_o,
	output logic                tap_last_o,
	output logic                patch_last_o
);

	conv_pkg::seq_state_t state;
	conv_pkg::buf_addr_t  origin;     // top left pixel of current patch
	conv_pkg::buf_addr_t  rd_ptr;
	conv_pkg::rom_addr_t  wt_cnt;
	conv_pkg::count_t     need;       // index of the patch's last pixel
	logic [2:0]           col;        // patch column within the row
	logic [3:0]           tap_cnt;    // tap within one channel
	logic [1:0]           strip_cnt;  // tap within one kernel row
	logic                 chan_end;

	// add with wrap around the circular buffer
	function automatic conv_pkg::buf_addr_t wrap_add(conv_pkg::buf_addr_t a, int step);
		int sum;
		sum = int'(a) + step;
		if (sum >= conv_pkg::BUF_DEPTH)
			sum = sum - conv_pkg::BUF_DEPTH;
		return conv_pkg::buf_addr_t'(sum);
	endfunction

	assign chan_end = (tap_cnt == 4'(conv_pkg::TAPS - 1));

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state     <= conv_pkg::IDLE;
			origin    <= '0;
			rd_ptr    <= '0;
			wt_cnt    <= '0;
			need      <= conv_pkg::count_t'(conv_pkg::IWIDTH * (conv_pkg::KHEIGHT - 1)
				+ conv_pkg::KWIDTH - 1);   // first complete patch
			col       <= '0;
			tap_cnt   <= '0;
			strip_cnt <= '0;
		end else begin
			case (state)
			conv_pkg::IDLE: begin
				if (wr_count_i > need)
					state <= conv_pkg::INIT;
			end
			conv_pkg::INIT: begin
				rd_ptr <= origin;
				state  <= conv_pkg::ISSUE;
			end
			conv_pkg::ISSUE: begin
				wt_cnt <= patch_last_o ? '0 : wt_cnt + 1'b1;
				if (chan_end) begin
					rd_ptr    <= origin;   // same patch, next channel
					tap_cnt   <= '0;
					strip_cnt <= '0;
				end else begin
					tap_cnt <= tap_cnt + 1'b1;
					if (strip_cnt == 2'(conv_pkg::KWIDTH - 1)) begin
						strip_cnt <= '0;
						rd_ptr    <= wrap_add(rd_ptr,
							conv_pkg::IWIDTH - conv_pkg::KWIDTH + 1);   // down one row
					end else begin
						strip_cnt <= strip_cnt + 1'b1;
						rd_ptr    <= wrap_add(rd_ptr, 1);
					end
				end
				if (patch_last_o)
					state <= conv_pkg::ADVANCE;
			end
			conv_pkg::ADVANCE: begin
				if (col == 3'(conv_pkg::IWIDTH - conv_pkg::KWIDTH)) begin
					// row end, step over the edge columns
					col    <= '0;
					origin <= wrap_add(origin, conv_pkg::KWIDTH);
					need   <= need + conv_pkg::count_t'(conv_pkg::KWIDTH);
				end else begin
					col    <= col + 1'b1;
					origin <= wrap_add(origin, 1);
					need   <= need + 1'b1;
				end
				state <= conv_pkg::IDLE;
			end
			default: state <= conv_pkg::IDLE;
			endcase
		end
	end

	assign rd_addr_o    = rd_ptr;
	assign wt_addr_o    = wt_cnt;
	assign tap_valid_o  = (state == conv_pkg::ISSUE);
	assign tap_first_o  = tap_valid_o && (tap_cnt == '0);
	assign tap_last_o   = tap_valid_o && chan_end;
	assign patch_last_o = tap_last_o
		&& (wt_cnt == conv_pkg::rom_addr_t'(conv_pkg::ROM_DEPTH - 1));

	// tap counters sit at zero whenever no patch is being issued
	a_state_legal : assert property (@(posedge clk_i) disable iff (reset_i)
		!$isunknown(state) && ((state == conv_pkg::ISSUE)
		|| (tap_cnt == '0 && strip_cnt == '0 && wt_cnt == '0)));

	// a channel ends on the last tap of a kernel row
	a_last_is_valid : assert property (@(posedge clk_i) disable iff (reset_i)
		tap_last_o |-> tap_valid_o && (strip_cnt == 2'(conv_pkg::KWIDTH - 1)));

endmodule

/* conv_mac_requant.sv */
// ############################
// mac and requantize
// ############################

`timescale 1ns/1ps

module conv_mac_requant (
	input  logic              clk_i,
	input  logic              reset_i,
	input  conv_pkg::sample_t pixel_i,
	input  conv_pkg::sample_t weight_i,
	input  logic              tap_valid_i,
	input  logic              tap_first_i,
	input  logic              tap_last_i,
	input  logic              patch_last_i,
	output conv_pkg::sample_t tdata_o,
	output logic              tvalid_o,
	output logic              tlast_o
);

	// flag delay lines, oldest bit lines up with read data
	logic [conv_pkg::READ_LAT-1:0] valid_d;
	logic [conv_pkg::READ_LAT-1:0] first_d;
	logic [conv_pkg::READ_LAT-1:0] last_d;
	logic [conv_pkg::READ_LAT-1:0] plast_d;

	conv_pkg::acc_t prod;
	conv_pkg::acc_t acc;
	logic           m_valid, m_first, m_last, m_plast;   // product stage flags
	logic           a_done, a_plast;                      // accumulate stage flags

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			valid_d <= '0;
			first_d <= '0;
			last_d  <= '0;
			plast_d <= '0;
			m_valid <= 1'b0;
			m_first <= 1'b0;
			m_last  <= 1'b0;
			m_plast <= 1'b0;
			a_done  <= 1'b0;
			a_plast <= 1'b0;
		end else begin
			valid_d <= {valid_d[conv_pkg::READ_LAT-2:0], tap_valid_i};
			first_d <= {first_d[conv_pkg::READ_LAT-2:0], tap_first_i};
			last_d  <= {last_d[conv_pkg::READ_LAT-2:0], tap_last_i};
			plast_d <= {plast_d[conv_pkg::READ_LAT-2:0], patch_last_i};
			m_valid <= valid_d[conv_pkg::READ_LAT-1];
			m_first <= first_d[conv_pkg::READ_LAT-1];
			m_last  <= last_d[conv_pkg::READ_LAT-1];
			m_plast <= plast_d[conv_pkg::READ_LAT-1];
			a_done  <= m_valid && m_last;
			a_plast <= m_valid && m_plast;
		end
	end

	always_ff @(posedge clk_i) begin
		prod <= pixel_i * weight_i;   // sign extended to 48 bits
		if (m_valid)
			acc <= m_first ? prod : acc + prod;   // first tap restarts the sum
	end

	// relu, clip, then slice out the fixed point result
	always_ff @(posedge clk_i) begin
		if (a_done) begin
			if (acc < 0)
				tdata_o <= '0;
			else if (acc >= (conv_pkg::acc_t'(1) <<< conv_pkg::ACC_TOP))
				tdata_o <= conv_pkg::SAMPLE_MAX;
			else
				tdata_o <= acc[conv_pkg::ACC_TOP -: 18];
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			tvalid_o <= 1'b0;
			tlast_o  <= 1'b0;
		end else begin
			tvalid_o <= a_done;   // single cycle pulse
			tlast_o  <= a_plast;
		end
	end

	a_last_with_valid : assert property (@(posedge clk_i) disable iff (reset_i)
		tlast_o |-> tvalid_o);

endmodule

/* conv2d_layer.sv */
// ############################
// conv2d layer top
// ############################

`timescale 1ns/1ps

module conv2d_layer (
	input  logic              clk,
	input  logic              reset,
	input  conv_pkg::sample_t tdata_i,
	input  logic              tvalid_i,
	output conv_pkg::sample_t tdata_o,
	output logic              tvalid_o,
	output logic              tlast_o
);

	conv_pkg::count_t    wr_count;
	conv_pkg::buf_addr_t rd_addr;
	conv_pkg::rom_addr_t wt_addr;
	conv_pkg::sample_t   pixel_rd;
	conv_pkg::sample_t   weight_rd;
	logic                tap_valid;
	logic                tap_first;
	logic                tap_last;
	logic                patch_last;

	conv_row_buffer i_row_buffer (
		.clk_i         (clk),
		.reset_i       (reset),
		.pixel_i       (tdata_i),
		.pixel_valid_i (tvalid_i),
		.rd_addr_i     (rd_addr),
		.pixel_o       (pixel_rd),
		.wr_count_o    (wr_count)
	);

	conv_weight_rom i_weight_rom (
		.clk_i     (clk),
		.wt_addr_i (wt_addr),
		.weight_o  (weight_rd)
	);

	conv_patch_sequencer i_sequencer (
		.clk_i        (clk),
		.reset_i      (reset),
		.wr_count_i   (wr_count),
		.rd_addr_o    (rd_addr),
		.wt_addr_o    (wt_addr),
		.tap_valid_o  (tap_valid),
		.tap_first_o  (tap_first),
		.tap_last_o   (tap_last),
		.patch_last_o (patch_last)
	);

	conv_mac_requant i_mac (
		.clk_i        (clk),
		.reset_i      (reset),
		.pixel_i      (pixel_rd),
		.weight_i     (weight_rd),
		.tap_valid_i  (tap_valid),
		.tap_first_i  (tap_first),
		.tap_last_i   (tap_last),
		.patch_last_i (patch_last),
		.tdata_o      (tdata_o),
		.tvalid_o     (tvalid_o),
		.tlast_o      (tlast_o)
	);

endmodule

/* tb_conv2d_layer.sv */
// ############################
// conv2d layer testbench
// ############################

`timescale 1ns/1ps

module tb_conv2d_layer;

	localparam int IHEIGHT       = 6;   // rows per frame
	localparam int SEED          = 32'hef01108c;
	localparam int CLK_PERIOD    = 40;
	localparam int GAP_MIN       = 39;   // sequencer time for one patch
	localparam int PULSE_TIMEOUT = 60;
	localparam int DRAIN_TIMEOUT = 400;
	localparam int OUT_ROWS      = IHEIGHT - conv_pkg::KHEIGHT + 1;
	localparam int OUT_COLS      = conv_pkg::IWIDTH - conv_pkg::KWIDTH + 1;
	localparam int FRAME_PULSES  = OUT_ROWS * OUT_COLS * conv_pkg::OCHAN;
	localparam int KIND_RANDOM   = 0;
	localparam int KIND_NEG      = 1;
	localparam int KIND_MAX      = 2;

	logic              clk;
	logic              reset;
	conv_pkg::sample_t tdata_i;
	logic              tvalid_i;
	conv_pkg::sample_t tdata_o;
	logic              tvalid_o;
	logic              tlast_o;

	integer            seed;
	conv_pkg::sample_t model_wts [conv_pkg::ROM_DEPTH];
	conv_pkg::sample_t frame [IHEIGHT][conv_pkg::IWIDTH];
	logic              relu_chan [conv_pkg::OCHAN];   // negative frame must give 0
	logic              clip_chan [conv_pkg::OCHAN];   // max frame must saturate
	conv_pkg::sample_t exp_q [$];     // expected tdata_o in output order
	int                start_q [$];   // cycle of the pixel completing each patch
	int                frame_kind;
	int                cycle_cnt;
	logic              reset_seen;    // reset as taken by the last rising edge
	int                pulse_cnt;
	int                chan_idx;
	int                cur_start;
	int                last_pulse;

	conv2d_layer i_dut (
		.clk      (clk),
		.reset    (reset),
		.tdata_i  (tdata_i),
		.tvalid_i (tvalid_i),
		.tdata_o  (tdata_o),
		.tvalid_o (tvalid_o),
		.tlast_o  (tlast_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt  <= cycle_cnt + 1;
		reset_seen <= reset;
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_sample(input string name, input conv_pkg::sample_t got,
		input conv_pkg::sample_t expected);
		if (got !== expected)
			stop_on_error($sformatf("[ERROR] %s got 0x%05h expected 0x%05h",
				name, got, expected));
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected)
			stop_on_error($sformatf("[ERROR] %s got 0x%0h expected 0x%0h",
				name, got, expected));
	endtask

	// relu, then clip at 2**ACC_TOP, else the 18 bits ending at ACC_TOP
	function automatic conv_pkg::sample_t requantize(input longint acc);
		if (acc < 0)
			return '0;
		if (acc >= (longint'(1) <<< conv_pkg::ACC_TOP))
			return conv_pkg::SAMPLE_MAX;
		return conv_pkg::sample_t'(acc >>> (conv_pkg::ACC_TOP - 17));
	endfunction

	function automatic longint patch_sum(input int r0, input int c0, input int ch);
		longint sum;
		sum = 0;
		for (int i = 0; i < conv_pkg::KHEIGHT; i++)
			for (int j = 0; j < conv_pkg::KWIDTH; j++)
				sum += longint'(frame[r0 + i][c0 + j])
					* longint'(model_wts[ch * conv_pkg::TAPS + i * conv_pkg::KWIDTH + j]);
		return sum;
	endfunction

	task automatic classify_weights();
		longint pos;
		longint neg;
		logic   any_relu;
		logic   any_clip;
		any_relu = 1'b0;
		any_clip = 1'b0;
		for (int k = 0; k < conv_pkg::OCHAN; k++) begin
			pos = 0;
			neg = 0;
			for (int t = 0; t < conv_pkg::TAPS; t++) begin
				if ($isunknown(model_wts[k * conv_pkg::TAPS + t]))
					stop_on_error("weights.mem could not be read by the model");
				if (model_wts[k * conv_pkg::TAPS + t] < 0)
					neg -= longint'(model_wts[k * conv_pkg::TAPS + t]);
				else
					pos += longint'(model_wts[k * conv_pkg::TAPS + t]);
			end
			// negative pixels span a factor of two at most
			relu_chan[k] = (pos > 2 * neg);
			clip_chan[k] = ((pos - neg) * longint'(conv_pkg::SAMPLE_MAX)
				>= (longint'(1) <<< conv_pkg::ACC_TOP));
			any_relu = any_relu | relu_chan[k];
			any_clip = any_clip | clip_chan[k];
		end
		if (!any_relu || !any_clip)
			stop_on_error("weights.mem has no channel that shows ReLU or clipping");
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset    = 1'b1;
		tvalid_i = 1'b0;
		tdata_i  = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic fill_frame(input int kind);
		for (int r = 0; r < IHEIGHT; r++) begin
			for (int c = 0; c < conv_pkg::IWIDTH; c++) begin
				case (kind)
				KIND_NEG: frame[r][c] = conv_pkg::sample_t'(-65536
					- int'($random(seed) & 32'h0000ffff));   // -131071 .. -65536
				KIND_MAX: frame[r][c] = conv_pkg::SAMPLE_MAX;
				default:  frame[r][c] = conv_pkg::sample_t'($random(seed));
				endcase
			end
		end
	endtask

	task automatic queue_patch(input int r0, input int c0);
		start_q.push_back(cycle_cnt);
		for (int ch = 0; ch < conv_pkg::OCHAN; ch++)
			exp_q.push_back(requantize(patch_sum(r0, c0, ch)));
	endtask

	task automatic send_frame();
		int gap;
		for (int r = 0; r < IHEIGHT; r++) begin
			for (int c = 0; c < conv_pkg::IWIDTH; c++) begin
				tdata_i  = frame[r][c];
				tvalid_i = 1'b1;
				if (r >= conv_pkg::KHEIGHT - 1 && c >= conv_pkg::KWIDTH - 1)
					queue_patch(r - conv_pkg::KHEIGHT + 1, c - conv_pkg::KWIDTH + 1);
				@(negedge clk);
				tvalid_i = 1'b0;
				gap = GAP_MIN + ($random(seed) & 7);
				repeat (gap) @(negedge clk);
			end
		end
	endtask

	task automatic drain_frame();
		int waited;
		waited = 0;
		while (pulse_cnt < FRAME_PULSES) begin
			if (waited == DRAIN_TIMEOUT)
				stop_on_error("timed out waiting for the output pulses of the frame");
			@(negedge clk);
			waited++;
		end
		repeat (2 * PULSE_TIMEOUT) @(negedge clk);   // room for stray pulses
		if (pulse_cnt != FRAME_PULSES)
			stop_on_error($sformatf("frame gave %0d output pulses instead of %0d",
				pulse_cnt, FRAME_PULSES));
		if (exp_q.size() != 0 || start_q.size() != 0)
			stop_on_error("expected results were left over after the frame drained");
	endtask

	task automatic run_frame(input int kind);
		frame_kind = kind;
		apply_reset();
		fill_frame(kind);
		send_frame();
		drain_frame();
	endtask

	task automatic take_pulse();
		conv_pkg::sample_t expected;
		if (exp_q.size() == 0)
			stop_on_error("tvalid_o pulsed before a complete patch was sent");
		if (chan_idx == 0)
			cur_start = start_q.pop_front();
		else if (cycle_cnt - last_pulse != conv_pkg::TAPS)
			stop_on_error($sformatf("channel pulses came %0d cycles apart instead of %0d",
				cycle_cnt - last_pulse, conv_pkg::TAPS));
		if (cycle_cnt - cur_start > PULSE_TIMEOUT)
			stop_on_error("output pulse came too late after the pixel completing its patch");
		expected = exp_q.pop_front();
		if (frame_kind == KIND_NEG && relu_chan[chan_idx])
			check_sample("tdata_o", tdata_o, '0);
		if (frame_kind == KIND_MAX && clip_chan[chan_idx])
			check_sample("tdata_o", tdata_o, conv_pkg::SAMPLE_MAX);
		check_sample("tdata_o", tdata_o, expected);
		check_flag("tlast_o", tlast_o, chan_idx == conv_pkg::OCHAN - 1);
		last_pulse = cycle_cnt;
		pulse_cnt++;
		chan_idx = (chan_idx + 1) % conv_pkg::OCHAN;
	endtask

	// outputs only change on rising edges
	always @(negedge clk) begin
		if (cycle_cnt > 0) begin
			if (reset_seen) begin
				check_flag("tvalid_o", tvalid_o, 1'b0);
				check_flag("tlast_o", tlast_o, 1'b0);
				pulse_cnt = 0;
				chan_idx  = 0;
			end else if (tvalid_o) begin
				take_pulse();
			end else begin
				check_flag("tlast_o", tlast_o, 1'b0);
			end
		end
	end

	initial begin
		clk        = 1'b0;
		reset      = 1'b1;
		tvalid_i   = 1'b0;
		tdata_i    = '0;
		seed       = SEED;
		frame_kind = KIND_RANDOM;
		reset_seen = 1'b0;
		pulse_cnt  = 0;
		chan_idx   = 0;
		cur_start  = 0;
		last_pulse = 0;
		$readmemb("weights.mem", model_wts);
		classify_weights();
		run_frame(KIND_RANDOM);
		run_frame(KIND_NEG);
		run_frame(KIND_MAX);
		run_frame(KIND_RANDOM);   // fresh frame after another reset
		if (exp_q.size() == 0 && start_q.size() == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			stop_on_error("expected results were left over at the end of the run");
		end
	end

endmodule

/* list.f */
conv_pkg.sv
conv_row_buffer.sv
conv_weight_rom.sv
conv_patch_sequencer.sv
conv_mac_requant.sv
conv2d_layer.sv
tb_conv2d_layer.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the conv2d layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f list.f --top-module tb_conv2d_layer -Mdir obj_dir -o sim_conv2d
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_conv2d 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TEST RESULT: PASS"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* weights.mem */
// one 18-bit two's complement weight per line, 9 taps per channel, channel 0 first
010000000000000000
011000000000000000
010000000000000000
011000000000000000
011111111111111111
011000000000000000
010000000000000000
011000000000000000
010000000000000000
011000000000000000
111100000000000000
011000000000000000
001100000000000000
011100000000000000
001100000000000000
011000000000000000
111100000000000000
011000000000000000
011111111111111111
100000000000000000
000001000000000000
110000000000000000
010010000000000000
111111100000000000
000000010000000000
111110000000000000
000000001000000000
111000000000000000
110000000000000000
111000000000000000
110000000000000000
100000000000000000
110000000000000000
111000000000000000
110000000000000000
000100000000000000
